//--- compile.f
+incdir+include
src/udp_loopback_pkg.sv
src/udp_payload_fifo.sv
src/udp_hdr_swap.sv
src/udp_loopback_ctrl.sv
src/udp_loopback_top.sv
tests/tb_udp_loopback.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_udp_loopback -f compile.f --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"
exit 0

//--- tests/tb_udp_loopback.sv
`timescale 1ns/1ps

module tb_udp_loopback;

    localparam int          CLK_PERIOD = 8;
    localparam int          TIMEOUT    = 2000;
    localparam logic [31:0] SEED       = 32'hb3ec_4245;

    // Reply fields the loopback must produce
    localparam logic [15:0] LOOP_PORT = 16'd1234;
    localparam logic [31:0] LOCAL_IP  = 32'hc0a8_0180;
    localparam logic [7:0]  REPLY_TTL = 8'd64;

    logic        clk_125mhz;
    logic        rst_125mhz;
    logic        rx_hdr_valid;
    logic        rx_hdr_ready;
    logic [31:0] rx_ip_source_ip;
    logic [15:0] rx_source_port;
    logic [15:0] rx_dest_port;
    logic [15:0] rx_udp_length;
    logic [7:0]  rx_payload_tdata;
    logic        rx_payload_tvalid;
    logic        rx_payload_tready;
    logic        rx_payload_tlast;
    logic        rx_payload_tuser;
    logic        tx_hdr_valid;
    logic        tx_hdr_ready;
    logic [31:0] tx_ip_source_ip;
    logic [31:0] tx_ip_dest_ip;
    logic [7:0]  tx_ip_ttl;
    logic [15:0] tx_source_port;
    logic [15:0] tx_dest_port;
    logic [15:0] tx_udp_length;
    logic [7:0]  tx_payload_tdata;
    logic        tx_payload_tvalid;
    logic        tx_payload_tready;
    logic        tx_payload_tlast;
    logic        tx_payload_tuser;
    logic [7:0]  led;

    logic         bp_enable;
    logic [7:0]   exp_led;
    int           errors;
    int           checks;

    // Headers are {src ip, dst ip, ttl, src port, dst port, length}
    // Beats are {user, last, data}
    logic [119:0] exp_hdr[$];
    logic [119:0] got_hdr[$];
    logic [9:0]   exp_beat[$];
    logic [9:0]   got_beat[$];

    udp_loopback_top dut_i (.*);

    initial clk_125mhz = 1'b0;
    always #(CLK_PERIOD / 2) clk_125mhz = ~clk_125mhz;

    // Transmit side sink, randomly stalls while bp_enable is set
    initial begin
        tx_hdr_ready      = 1'b1;
        tx_payload_tready = 1'b1;
        forever begin
            @(negedge clk_125mhz);
            tx_hdr_ready      = bp_enable ? 1'($urandom) : 1'b1;
            tx_payload_tready = bp_enable ? 1'($urandom) : 1'b1;
        end
    end

    // Collector for everything the DUT transmits
    always @(posedge clk_125mhz) begin
        if (!rst_125mhz) begin
            if (tx_hdr_valid && tx_hdr_ready) begin
                got_hdr.push_back({tx_ip_source_ip, tx_ip_dest_ip, tx_ip_ttl,
                                   tx_source_port, tx_dest_port, tx_udp_length});
            end
            if (tx_payload_tvalid && tx_payload_tready) begin
                got_beat.push_back({tx_payload_tuser, tx_payload_tlast, tx_payload_tdata});
            end
        end
    end

    task automatic check_eq(input logic [119:0] actual, input logic [119:0] expected,
                            input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at time %0t: %s, got %0h, expected %0h",
                     $time, msg, actual, expected);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout after %0d cycles while waiting for %s", TIMEOUT, what);
        $display("Errors: %0d, checks: %0d", errors, checks);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // Pushes one header and its payload, recording what should come back
    task automatic send_frame(input logic [31:0] src_ip, input logic [15:0] src_port,
                              input logic [15:0] dst_port, input int nbytes);
        logic [7:0] data;
        logic       user;
        logic       match;
        int         cycles;
        int         i;
        match = (dst_port == LOOP_PORT);
        if (match) begin
            exp_hdr.push_back({LOCAL_IP, src_ip, REPLY_TTL, dst_port, src_port,
                               16'(nbytes + 8)});
        end
        @(negedge clk_125mhz);
        rx_hdr_valid    = 1'b1;
        rx_ip_source_ip = src_ip;
        rx_source_port  = src_port;
        rx_dest_port    = dst_port;
        rx_udp_length   = 16'(nbytes + 8);
        cycles = 0;
        do begin
            if (cycles == TIMEOUT) abort_on_timeout("rx_hdr_ready");
            @(posedge clk_125mhz);
            cycles++;
        end while (!rx_hdr_ready);
        @(negedge clk_125mhz);
        rx_hdr_valid = 1'b0;
        for (i = 0; i < nbytes; i++) begin
            data = 8'($urandom);
            user = 1'($urandom);
            if (match) begin
                exp_beat.push_back({user, (i == nbytes - 1), data});
                if (i == 0) exp_led = data;
            end
            rx_payload_tvalid = 1'b1;
            rx_payload_tdata  = data;
            rx_payload_tuser  = user;
            rx_payload_tlast  = (i == nbytes - 1);
            cycles = 0;
            do begin
                if (cycles == TIMEOUT) abort_on_timeout("rx_payload_tready");
                @(posedge clk_125mhz);
                cycles++;
            end while (!rx_payload_tready);
            @(negedge clk_125mhz);
        end
        rx_payload_tvalid = 1'b0;
        rx_payload_tlast  = 1'b0;
    endtask

    // Waits for the expected output, then looks for anything extra
    task automatic check_output(input string what);
        int cycles;
        int i;
        cycles = 0;
        while (got_hdr.size() < exp_hdr.size() || got_beat.size() < exp_beat.size()) begin
            if (cycles == TIMEOUT) abort_on_timeout({what, " output"});
            @(posedge clk_125mhz);
            cycles++;
        end
        repeat (20) @(posedge clk_125mhz);
        @(negedge clk_125mhz);
        check_eq(120'(got_hdr.size()), 120'(exp_hdr.size()), {what, ": header count"});
        check_eq(120'(got_beat.size()), 120'(exp_beat.size()), {what, ": beat count"});
        for (i = 0; i < exp_hdr.size() && i < got_hdr.size(); i++) begin
            check_eq(got_hdr[i], exp_hdr[i], $sformatf("%s: reply header %0d", what, i));
        end
        for (i = 0; i < exp_beat.size() && i < got_beat.size(); i++) begin
            check_eq(120'(got_beat[i]), 120'(exp_beat[i]),
                     $sformatf("%s: payload beat %0d", what, i));
        end
        exp_hdr.delete();
        got_hdr.delete();
        exp_beat.delete();
        got_beat.delete();
    endtask

    task automatic test_reset();
        check_eq(120'(tx_hdr_valid), 120'(0), "reset: tx_hdr_valid");
        check_eq(120'(tx_payload_tvalid), 120'(0), "reset: tx_payload_tvalid");
        check_eq(120'(rx_payload_tready), 120'(0), "reset: rx_payload_tready");
        check_eq(120'(led), 120'(0), "reset: led");
    endtask

    task automatic test_echo();
        send_frame(32'hc0a8_0105, 16'd5000, LOOP_PORT, int'($urandom_range(1, 16)));
        check_output("echo");
        check_eq(120'(led), 120'(exp_led), "echo: led");
    endtask

    task automatic test_drop();
        send_frame(32'hc0a8_0107, 16'd6000, 16'd80, 10);
        check_output("drop");
        check_eq(120'(led), 120'(exp_led), "drop: led unchanged");
    endtask

    task automatic test_backpressure();
        int         k;
        logic [15:0] port;
        bp_enable = 1'b1;
        for (k = 0; k < 12; k++) begin
            // Every third frame goes to a port that is not echoed
            port = (k % 3 == 1) ? 16'd53 : LOOP_PORT;
            send_frame($urandom, 16'($urandom), port, int'($urandom_range(1, 24)));
        end
        check_output("back-pressure");
        check_eq(120'(led), 120'(exp_led), "back-pressure: led");
        bp_enable = 1'b0;
    endtask

    initial begin
        errors            = 0;
        checks            = 0;
        bp_enable         = 1'b0;
        exp_led           = 8'd0;
        void'($urandom(SEED));
        rst_125mhz        = 1'b1;
        rx_hdr_valid      = 1'b0;
        rx_ip_source_ip   = 32'd0;
        rx_source_port    = 16'd0;
        rx_dest_port      = 16'd0;
        rx_udp_length     = 16'd0;
        rx_payload_tdata  = 8'd0;
        rx_payload_tvalid = 1'b0;
        rx_payload_tlast  = 1'b0;
        rx_payload_tuser  = 1'b0;
        repeat (10) @(posedge clk_125mhz);
        @(negedge clk_125mhz);
        rst_125mhz = 1'b0;
        test_reset();
        test_echo();
        test_drop();
        test_backpressure();
        $display("Errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- src/udp_loopback_top.sv
`timescale 1ns/1ps

`include "udp_loopback_macros.svh"

module udp_loopback_top (
    input  logic                        clk_125mhz,
    input  logic                        rst_125mhz,

    // Received UDP header
    input  logic                        rx_hdr_valid,
    output logic                        rx_hdr_ready,
    input  udp_loopback_pkg::ip_addr_t  rx_ip_source_ip,
    input  udp_loopback_pkg::udp_port_t rx_source_port,
    input  udp_loopback_pkg::udp_port_t rx_dest_port,
    input  udp_loopback_pkg::udp_len_t  rx_udp_length,

    // Received UDP payload
    input  udp_loopback_pkg::pay_byte_t rx_payload_tdata,
    input  logic                        rx_payload_tvalid,
    output logic                        rx_payload_tready,
    input  logic                        rx_payload_tlast,
    input  logic                        rx_payload_tuser,

    // Reply UDP header
    output logic                        tx_hdr_valid,
    input  logic                        tx_hdr_ready,
    output udp_loopback_pkg::ip_addr_t  tx_ip_source_ip,
    output udp_loopback_pkg::ip_addr_t  tx_ip_dest_ip,
    output udp_loopback_pkg::ttl_t      tx_ip_ttl,
    output udp_loopback_pkg::udp_port_t tx_source_port,
    output udp_loopback_pkg::udp_port_t tx_dest_port,
    output udp_loopback_pkg::udp_len_t  tx_udp_length,

    // Reply UDP payload
    output udp_loopback_pkg::pay_byte_t tx_payload_tdata,
    output logic                        tx_payload_tvalid,
    input  logic                        tx_payload_tready,
    output logic                        tx_payload_tlast,
    output logic                        tx_payload_tuser,

    output udp_loopback_pkg::pay_byte_t led
);
    import udp_loopback_pkg::*;

    logic      hdr_load;
    logic      hdr_full;
    logic      wr_valid;
    logic      wr_ready;
    pay_byte_t wr_data;
    logic      wr_last;
    logic      wr_user;

    udp_loopback_ctrl ctrl_i (
        .clk_125mhz        (clk_125mhz),
        .rst_125mhz        (rst_125mhz),
        .rx_hdr_valid      (rx_hdr_valid),
        .rx_hdr_ready      (rx_hdr_ready),
        .rx_dest_port      (rx_dest_port),
        .rx_payload_tdata  (rx_payload_tdata),
        .rx_payload_tvalid (rx_payload_tvalid),
        .rx_payload_tready (rx_payload_tready),
        .rx_payload_tlast  (rx_payload_tlast),
        .rx_payload_tuser  (rx_payload_tuser),
        .hdr_load          (hdr_load),
        .hdr_full          (hdr_full),
        .wr_valid          (wr_valid),
        .wr_ready          (wr_ready),
        .wr_data           (wr_data),
        .wr_last           (wr_last),
        .wr_user           (wr_user),
        .tx_payload_tdata  (tx_payload_tdata),
        .tx_payload_tvalid (tx_payload_tvalid),
        .tx_payload_tready (tx_payload_tready),
        .tx_payload_tlast  (tx_payload_tlast),
        .led               (led)
    );

    udp_hdr_swap hdr_swap_i (
        .clk_125mhz      (clk_125mhz),
        .rst_125mhz      (rst_125mhz),
        .hdr_load        (hdr_load),
        .hdr_full        (hdr_full),
        .rx_ip_source_ip (rx_ip_source_ip),
        .rx_source_port  (rx_source_port),
        .rx_dest_port    (rx_dest_port),
        .rx_udp_length   (rx_udp_length),
        .tx_hdr_valid    (tx_hdr_valid),
        .tx_hdr_ready    (tx_hdr_ready),
        .tx_ip_source_ip (tx_ip_source_ip),
        .tx_ip_dest_ip   (tx_ip_dest_ip),
        .tx_ip_ttl       (tx_ip_ttl),
        .tx_source_port  (tx_source_port),
        .tx_dest_port    (tx_dest_port),
        .tx_udp_length   (tx_udp_length)
    );

    // Read side of the FIFO is the reply payload port
    udp_payload_fifo #(
        .DEPTH (`UDP_FIFO_DEPTH)
    ) fifo_i (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .wr_valid   (wr_valid),
        .wr_ready   (wr_ready),
        .wr_data    (wr_data),
        .wr_last    (wr_last),
        .wr_user    (wr_user),
        .rd_valid   (tx_payload_tvalid),
        .rd_ready   (tx_payload_tready),
        .rd_data    (tx_payload_tdata),
        .rd_last    (tx_payload_tlast),
        .rd_user    (tx_payload_tuser)
    );

endmodule

//--- src/udp_loopback_ctrl.sv
`timescale 1ns/1ps

`include "udp_loopback_macros.svh"

module udp_loopback_ctrl (
    input  logic                        clk_125mhz,
    input  logic                        rst_125mhz,

    // Received header
    input  logic                        rx_hdr_valid,
    output logic                        rx_hdr_ready,
    input  udp_loopback_pkg::udp_port_t rx_dest_port,

    // Received payload
    input  udp_loopback_pkg::pay_byte_t rx_payload_tdata,
    input  logic                        rx_payload_tvalid,
    output logic                        rx_payload_tready,
    input  logic                        rx_payload_tlast,
    input  logic                        rx_payload_tuser,

    // Reply header buffer
    output logic                        hdr_load,
    input  logic                        hdr_full,

    // Payload FIFO write side
    output logic                        wr_valid,
    input  logic                        wr_ready,
    output udp_loopback_pkg::pay_byte_t wr_data,
    output logic                        wr_last,
    output logic                        wr_user,

    // Transmit payload, observed only
    input  udp_loopback_pkg::pay_byte_t tx_payload_tdata,
    input  logic                        tx_payload_tvalid,
    input  logic                        tx_payload_tready,
    input  logic                        tx_payload_tlast,

    output udp_loopback_pkg::pay_byte_t led
);
    import udp_loopback_pkg::*;

    loop_state_t state;
    logic        dest_match;
    logic        hdr_fire;
    logic        pay_fire;
    logic        tx_fire;
    logic        first_beat;

    assign dest_match = (rx_dest_port == `UDP_LOOP_PORT);

    // A matching header has to wait for the reply buffer to empty
    assign rx_hdr_ready = (state == LOOP_IDLE) && (!dest_match || !hdr_full);
    assign hdr_fire     = rx_hdr_valid && rx_hdr_ready;
    assign hdr_load     = hdr_fire && dest_match;

    // Payload steering
    assign wr_valid = rx_payload_tvalid && (state == LOOP_PASS);
    assign wr_data  = rx_payload_tdata;
    assign wr_last  = rx_payload_tlast;
    assign wr_user  = rx_payload_tuser;

    // Dropped frames are drained at full rate
    assign rx_payload_tready = (state == LOOP_DROP) || ((state == LOOP_PASS) && wr_ready);
    assign pay_fire          = rx_payload_tvalid && rx_payload_tready;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state <= LOOP_IDLE;
        end else begin
            case (state)
                LOOP_IDLE: begin
                    if (hdr_fire) begin
                        state <= dest_match ? LOOP_PASS : LOOP_DROP;
                    end
                end
                LOOP_PASS, LOOP_DROP: begin
                    if (pay_fire && rx_payload_tlast) begin
                        state <= LOOP_IDLE;
                    end
                end
                default: begin
                    state <= LOOP_IDLE;
                end
            endcase
        end
    end

    // First byte of every transmitted frame goes to the LEDs
    assign tx_fire = tx_payload_tvalid && tx_payload_tready;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            first_beat <= 1'b1;
            led        <= '0;
        end else if (tx_fire) begin
            if (first_beat) begin
                led <= tx_payload_tdata;
            end
            // Next beat after a last one starts a new frame
            first_beat <= tx_payload_tlast;
        end
    end

    // Header port closes once a frame has started
    a_hdr_ready_idle: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        hdr_fire |=> !rx_hdr_ready)
        else $error("rx_hdr_ready high right after a header was accepted");

    // Payload of a dropped frame never reaches the FIFO
    a_no_write_in_drop: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        (hdr_fire && !dest_match) |=> !wr_valid)
        else $error("FIFO write offered for a dropped frame");

endmodule

//--- src/udp_hdr_swap.sv
`timescale 1ns/1ps

`include "udp_loopback_macros.svh"

module udp_hdr_swap (
    input  logic                        clk_125mhz,
    input  logic                        rst_125mhz,

    // Load from the received header
    input  logic                        hdr_load,
    output logic                        hdr_full,
    input  udp_loopback_pkg::ip_addr_t  rx_ip_source_ip,
    input  udp_loopback_pkg::udp_port_t rx_source_port,
    input  udp_loopback_pkg::udp_port_t rx_dest_port,
    input  udp_loopback_pkg::udp_len_t  rx_udp_length,

    // Reply header
    output logic                        tx_hdr_valid,
    input  logic                        tx_hdr_ready,
    output udp_loopback_pkg::ip_addr_t  tx_ip_source_ip,
    output udp_loopback_pkg::ip_addr_t  tx_ip_dest_ip,
    output udp_loopback_pkg::ttl_t      tx_ip_ttl,
    output udp_loopback_pkg::udp_port_t tx_source_port,
    output udp_loopback_pkg::udp_port_t tx_dest_port,
    output udp_loopback_pkg::udp_len_t  tx_udp_length
);
    import udp_loopback_pkg::*;

    logic      full;
    ip_addr_t  peer_ip;
    udp_port_t src_port;
    udp_port_t dst_port;
    udp_len_t  length;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            full <= 1'b0;
        end else if (hdr_load) begin
            full <= 1'b1;
        end else if (tx_hdr_valid && tx_hdr_ready) begin
            full <= 1'b0;
        end
    end

    // Ports swap so the reply returns to the sender's socket
    always_ff @(posedge clk_125mhz) begin
        if (hdr_load) begin
            peer_ip  <= rx_ip_source_ip;
            src_port <= rx_dest_port;
            dst_port <= rx_source_port;
            length   <= rx_udp_length;
        end
    end

    assign hdr_full        = full;
    assign tx_hdr_valid    = full;
    assign tx_ip_source_ip = `UDP_LOCAL_IP;
    assign tx_ip_dest_ip   = peer_ip;
    assign tx_ip_ttl       = `UDP_REPLY_TTL;
    assign tx_source_port  = src_port;
    assign tx_dest_port    = dst_port;
    assign tx_udp_length   = length;

    a_no_load_when_full: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        hdr_load |-> !full)
        else $error("Reply header loaded over a pending one");

endmodule

//--- src/udp_payload_fifo.sv
`timescale 1ns/1ps

`include "udp_loopback_macros.svh"

module udp_payload_fifo #(
    parameter int DEPTH = `UDP_FIFO_DEPTH
) (
    input  logic                        clk_125mhz,
    input  logic                        rst_125mhz,

    // Write side
    input  logic                        wr_valid,
    output logic                        wr_ready,
    input  udp_loopback_pkg::pay_byte_t wr_data,
    input  logic                        wr_last,
    input  logic                        wr_user,

    // Read side
    output logic                        rd_valid,
    input  logic                        rd_ready,
    output udp_loopback_pkg::pay_byte_t rd_data,
    output logic                        rd_last,
    output logic                        rd_user
);
    import udp_loopback_pkg::*;

    localparam int ADDR_W  = $clog2(DEPTH);
    localparam int ENTRY_W = $bits(pay_byte_t) + 2;
    localparam logic [ADDR_W:0] FULL_COUNT = (ADDR_W + 1)'(DEPTH);

    // Each entry holds {user, last, byte}
    logic [ENTRY_W-1:0] mem [DEPTH];
    logic [ENTRY_W-1:0] rd_entry;

    // Extra pointer bit tells full from empty
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic [ADDR_W:0] fill_count;
    logic            wr_en;
    logic            rd_en;

    assign fill_count = wr_ptr - rd_ptr;
    assign wr_ready   = (fill_count != FULL_COUNT);
    assign rd_valid   = (fill_count != '0);
    assign wr_en      = wr_valid && wr_ready;
    assign rd_en      = rd_valid && rd_ready;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= {wr_user, wr_last, wr_data};
        end
    end

    // Read data straight from the array, visible the cycle after the write
    assign rd_entry = mem[rd_ptr[ADDR_W-1:0]];
    assign rd_data  = rd_entry[ENTRY_W-3:0];
    assign rd_last  = rd_entry[ENTRY_W-2];
    assign rd_user  = rd_entry[ENTRY_W-1];

    // A beat offered while full stays offered until there is room
    a_no_overflow: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
        (wr_valid && !wr_ready) |=> wr_valid)
        else $error("Write offered to a full payload FIFO was dropped");

endmodule

//--- src/udp_loopback_pkg.sv
package udp_loopback_pkg;

    // IPv4 address
    typedef logic [31:0] ip_addr_t;

    // UDP header fields
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // IP time to live
    typedef logic [7:0] ttl_t;

    // One beat of the payload stream
    typedef logic [7:0] pay_byte_t;

    // Control FSM
    // LOOP_PASS forwards payload into the FIFO, LOOP_DROP drains it
    typedef enum logic [1:0] {
        LOOP_IDLE = 2'd0,
        LOOP_PASS = 2'd1,
        LOOP_DROP = 2'd2
    } loop_state_t;

endpackage

//--- include/udp_loopback_macros.svh
`ifndef UDP_LOOPBACK_MACROS_SVH
`define UDP_LOOPBACK_MACROS_SVH

// Destination port that gets echoed back to the sender
`define UDP_LOOP_PORT 16'd1234

// Local address 192.168.1.128
`define UDP_LOCAL_IP {8'd192, 8'd168, 8'd1, 8'd128}

// TTL placed in every reply
`define UDP_REPLY_TTL 8'd64

// Payload FIFO entries, must be a power of two
`define UDP_FIFO_DEPTH 16

`endif
